// ==== include/rvv_macros.svh ====
`ifndef RVV_MACROS_SVH
`define RVV_MACROS_SVH

// vector register width in bits
`define RVV_VLEN 64

// byte lanes across one register
`define RVV_LANES 8

// architectural vector registers
`define RVV_NUM_VEC 32

// register index width
`define RVV_REG_AW 5

// memory address, taken straight from the rs1 field
`define RVV_MEM_AW 5

// instruction word
`define RVV_INSN_W 32

// major opcodes, insn[6:0]
`define RVV_OPC_LOAD 7'h07
`define RVV_OPC_STORE 7'h27
`define RVV_OPC_VOP 7'h57

`endif

// ==== src/rvv_pkg.sv ====
`include "rvv_macros.svh"

package rvv_pkg;

    // major opcode field
    typedef enum logic [6:0] {
        OPC_LOAD  = `RVV_OPC_LOAD,
        OPC_STORE = `RVV_OPC_STORE,
        OPC_VOP   = `RVV_OPC_VOP
    } opc_major_e;

    // funct3 of the vector op space
    // cfg only recognized so it can retire as a no-op
    typedef enum logic [2:0] {
        OPC_IVV = 3'h0,
        OPC_IVI = 3'h3,
        OPC_CFG = 3'h7
    } opc_minor_e;

    // lane operation, pass forwards operand b
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } alu_op_e;

    // what the writeback stage does with a packet
    typedef enum logic [1:0] {
        KIND_ALU   = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } kind_e;

    // decoded instruction
    typedef struct packed {
        kind_e                  kind;
        alu_op_e                op;
        logic [`RVV_REG_AW-1:0] vd;
        logic [`RVV_REG_AW-1:0] vs1;
        // vs3 for stores
        logic [`RVV_REG_AW-1:0] vs2;
        logic                   use_imm;
        logic [7:0]             imm;
        logic [`RVV_MEM_AW-1:0] mem_addr;
    } issue_t;

    // packet entering the lanes
    typedef struct packed {
        issue_t               iss;
        logic [`RVV_VLEN-1:0] opa;
        logic [`RVV_VLEN-1:0] opb;
    } exec_t;

    // packet into writeback
    typedef struct packed {
        kind_e                  kind;
        logic [`RVV_REG_AW-1:0] vd;
        logic [`RVV_MEM_AW-1:0] mem_addr;
        logic [`RVV_VLEN-1:0]   result;
    } wb_t;

endpackage

// ==== src/vec_lane.sv ====
`timescale 1ns/10ps

module vec_lane (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  rvv_pkg::alu_op_e op,
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    output logic [7:0]       y
);
    import rvv_pkg::*;

    logic [7:0] res;

    // b is vs2, a is vs1 or the immediate
    // add and sub just wrap in 8 bits
    always_comb begin
        case (op)
            ALU_ADD: res = b + a;
            ALU_SUB: res = b - a;
            ALU_AND: res = b & a;
            ALU_OR:  res = b | a;
            ALU_XOR: res = b ^ a;
            // store data rides through here
            default: res = b;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            y <= '0;
        end else if (en) begin
            y <= res;
        end
    end

endmodule

// ==== src/vec_regfile.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module vec_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en,
    input  logic [`RVV_REG_AW-1:0] rd_addr_a,
    input  logic [`RVV_REG_AW-1:0] rd_addr_b,
    input  logic                   wr_en,
    input  logic [`RVV_REG_AW-1:0] wr_addr,
    input  logic [`RVV_VLEN-1:0]   wr_data,
    output logic [`RVV_VLEN-1:0]   rd_data_a,
    output logic [`RVV_VLEN-1:0]   rd_data_b
);

    logic [`RVV_VLEN-1:0] regs [`RVV_NUM_VEC];

    // all registers start at zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `RVV_NUM_VEC; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // registered reads
    // held while the pipe is frozen
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= regs[rd_addr_a];
            rd_data_b <= regs[rd_addr_b];
        end
    end

endmodule

// ==== src/rvv_decoder.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module rvv_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RVV_INSN_W-1:0] insn_in,
    input  logic                   wb_busy,
    input  logic                   clear_valid,
    input  logic [`RVV_REG_AW-1:0] clear_idx,
    output logic                   proc_rdy,
    output logic                   issue_valid,
    output rvv_pkg::issue_t        issue
);
    import rvv_pkg::*;

    logic [`RVV_INSN_W-1:0] insn_q;
    logic                   ready_q;
    logic [`RVV_NUM_VEC-1:0] pending;

    // raw fields
    opc_major_e             major;
    opc_minor_e             minor;
    logic [5:0]             funct6;
    logic [1:0]             mop;
    logic [`RVV_REG_AW-1:0] f_vd;
    logic [`RVV_REG_AW-1:0] f_vs1;
    logic [`RVV_REG_AW-1:0] f_vs2;

    alu_op_e fn_op;
    logic    fn_ok;
    issue_t  dec;
    logic    dec_valid;
    logic    hazard;
    logic    stall;
    logic    issue_fire;

    assign major  = opc_major_e'(insn_q[6:0]);
    assign minor  = opc_minor_e'(insn_q[14:12]);
    assign f_vd   = insn_q[11:7];
    assign f_vs1  = insn_q[19:15];
    assign f_vs2  = insn_q[24:20];
    assign mop    = insn_q[27:26];
    assign funct6 = insn_q[31:26];

    // funct6 to lane op, shared by vv and vi
    always_comb begin
        fn_ok = 1'b1;
        case (funct6)
            6'b000000: fn_op = ALU_ADD;
            6'b000010: fn_op = ALU_SUB;
            6'b001001: fn_op = ALU_AND;
            6'b001010: fn_op = ALU_OR;
            6'b001011: fn_op = ALU_XOR;
            default: begin
                fn_op = ALU_PASS;
                fn_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec          = '0;
        dec_valid    = 1'b0;
        dec.kind     = KIND_ALU;
        dec.op       = ALU_PASS;
        dec.vd       = f_vd;
        dec.vs1      = f_vs1;
        dec.vs2      = f_vs2;
        // simm5 sign-extended to one element
        dec.imm      = {{3{f_vs1[4]}}, f_vs1};
        dec.mem_addr = f_vs1;
        case (major)
            OPC_LOAD: begin
                dec.kind  = KIND_LOAD;
                // unit stride only
                dec_valid = (mop == 2'b00);
            end
            OPC_STORE: begin
                dec.kind  = KIND_STORE;
                // store data comes out of read port b
                dec.vs2   = f_vd;
                dec_valid = (mop == 2'b00);
            end
            OPC_VOP: begin
                case (minor)
                    OPC_IVV: begin
                        dec.op    = fn_op;
                        dec_valid = fn_ok;
                    end
                    OPC_IVI: begin
                        dec.op      = fn_op;
                        dec.use_imm = 1'b1;
                        // no vsub.vi in the ISA
                        dec_valid   = fn_ok && (fn_op != ALU_SUB);
                    end
                    OPC_CFG: dec_valid = 1'b0;
                    default: dec_valid = 1'b0;
                endcase
            end
            default: dec_valid = 1'b0;
        endcase
    end

    // raw on vs1 (vv only) and vs2/vs3, waw on vd
    always_comb begin
        hazard = 1'b0;
        if (dec_valid) begin
            if (dec.kind == KIND_ALU && !dec.use_imm && pending[dec.vs1]) begin
                hazard = 1'b1;
            end
            if (dec.kind != KIND_LOAD && pending[dec.vs2]) begin
                hazard = 1'b1;
            end
            if (dec.kind != KIND_STORE && pending[dec.vd]) begin
                hazard = 1'b1;
            end
        end
    end

    assign stall      = wb_busy | hazard;
    assign issue_fire = dec_valid & ~stall;
    assign proc_rdy   = ready_q & ~stall;

    // first cycle out of reset spent with capture cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_q <= 1'b0;
            insn_q  <= '0;
        end else begin
            ready_q <= 1'b1;
            if (proc_rdy) begin
                insn_q <= insn_in;
            end
        end
    end

    // issue register freezes under back-pressure, bubble on hazard
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issue_valid <= 1'b0;
        end else if (!wb_busy) begin
            issue_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!wb_busy) begin
            issue <= dec;
        end
    end

    // set and clear never hit the same index, set needs a clear bit
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= '0;
        end else begin
            if (clear_valid) begin
                pending[clear_idx] <= 1'b0;
            end
            if (issue_fire && dec.kind != KIND_STORE) begin
                pending[dec.vd] <= 1'b1;
            end
        end
    end

endmodule

// ==== src/vec_writeback.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module vec_writeback (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_valid,
    input  rvv_pkg::wb_t           wb,
    input  logic [`RVV_VLEN-1:0]   mem_port_in,
    input  logic                   mem_port_valid_in,
    output logic                   mem_port_ready_out,
    output logic [`RVV_VLEN-1:0]   mem_port_out,
    output logic [`RVV_MEM_AW-1:0] mem_port_addr_out,
    output logic                   mem_port_valid_out,
    output logic                   wr_en,
    output logic [`RVV_REG_AW-1:0] wr_addr,
    output logic [`RVV_VLEN-1:0]   wr_data,
    output logic                   clear_valid,
    output logic [`RVV_REG_AW-1:0] clear_idx,
    output logic                   wb_busy
);
    import rvv_pkg::*;

    logic v_q;
    wb_t  wb_q;
    logic is_alu;
    logic is_load;
    logic is_store;

    // stage register, held while a load waits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            v_q <= 1'b0;
        end else if (!wb_busy) begin
            v_q <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!wb_busy) begin
            wb_q <= wb;
        end
    end

    assign is_alu   = v_q && (wb_q.kind == KIND_ALU);
    assign is_load  = v_q && (wb_q.kind == KIND_LOAD);
    assign is_store = v_q && (wb_q.kind == KIND_STORE);

    // load request level, dropped by the data beat
    assign mem_port_ready_out = is_load;
    assign wb_busy            = is_load && !mem_port_valid_in;

    // store lasts one cycle since the stage moves on
    assign mem_port_valid_out = is_store;
    assign mem_port_out       = wb_q.result;
    // address stays put while the stage is frozen
    assign mem_port_addr_out  = wb_q.mem_addr;

    // alu result or load data back to the regfile
    assign wr_en   = is_alu || (is_load && mem_port_valid_in);
    assign wr_addr = wb_q.vd;
    assign wr_data = is_load ? mem_port_in : wb_q.result;

    // write releases the scoreboard bit on the same edge
    assign clear_valid = wr_en;
    assign clear_idx   = wb_q.vd;

endmodule

// ==== src/rvv_proc_main.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module rvv_proc_main (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RVV_INSN_W-1:0] insn_in,
    input  logic [`RVV_VLEN-1:0]   mem_port_in,
    input  logic                   mem_port_valid_in,
    output logic                   mem_port_ready_out,
    output logic [`RVV_VLEN-1:0]   mem_port_out,
    output logic [`RVV_MEM_AW-1:0] mem_port_addr_out,
    output logic                   mem_port_valid_out,
    output logic                   proc_rdy
);
    import rvv_pkg::*;

    logic                   issue_valid;
    issue_t                 issue;
    logic                   wb_busy;
    logic                   pipe_en;
    logic                   clear_valid;
    logic [`RVV_REG_AW-1:0] clear_idx;
    logic                   wr_en;
    logic [`RVV_REG_AW-1:0] wr_addr;
    logic [`RVV_VLEN-1:0]   wr_data;
    logic [`RVV_VLEN-1:0]   rd_data_a;
    logic [`RVV_VLEN-1:0]   rd_data_b;

    // read stage and lane stage
    logic                 rd_valid;
    issue_t               rd_iss;
    exec_t                ex;
    logic                 ln_valid;
    issue_t               ln_iss;
    logic [`RVV_VLEN-1:0] lane_y;
    wb_t                  wb_pkt;

    assign pipe_en = ~wb_busy;

    rvv_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .insn_in     (insn_in),
        .wb_busy     (wb_busy),
        .clear_valid (clear_valid),
        .clear_idx   (clear_idx),
        .proc_rdy    (proc_rdy),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    vec_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (pipe_en),
        .rd_addr_a (issue.vs1),
        .rd_addr_b (issue.vs2),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // valid bits move with the regfile read and the lane registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid <= 1'b0;
            ln_valid <= 1'b0;
        end else if (pipe_en) begin
            rd_valid <= issue_valid;
            ln_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            rd_iss <= issue;
            ln_iss <= ex.iss;
        end
    end

    // vi form puts the immediate in every byte
    assign ex.iss = rd_iss;
    assign ex.opa = rd_iss.use_imm ? {`RVV_LANES{rd_iss.imm}} : rd_data_a;
    assign ex.opb = rd_data_b;

    genvar g;
    generate
        for (g = 0; g < `RVV_LANES; g++) begin : g_lane
            vec_lane u_lane (
                .clk (clk),
                .rst (rst),
                .en  (pipe_en),
                .op  (ex.iss.op),
                .a   (ex.opa[8*g +: 8]),
                .b   (ex.opb[8*g +: 8]),
                .y   (lane_y[8*g +: 8])
            );
        end
    endgenerate

    assign wb_pkt.kind     = ln_iss.kind;
    assign wb_pkt.vd       = ln_iss.vd;
    assign wb_pkt.mem_addr = ln_iss.mem_addr;
    assign wb_pkt.result   = lane_y;

    vec_writeback u_writeback (
        .clk                (clk),
        .rst                (rst),
        .wb_valid           (ln_valid),
        .wb                 (wb_pkt),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .clear_valid        (clear_valid),
        .clear_idx          (clear_idx),
        .wb_busy            (wb_busy)
    );

endmodule

// ==== tb/rvv_sva.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module rvv_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   proc_rdy,
    input logic                   mem_port_ready_out,
    input logic                   mem_port_valid_in,
    input logic [`RVV_MEM_AW-1:0] mem_port_addr_out,
    input logic                   mem_port_valid_out
);

    // open load request keeps its level and address
    property p_load_hold;
        @(posedge clk) disable iff (!rst)
        (mem_port_ready_out && !mem_port_valid_in) |=>
            (mem_port_ready_out && $stable(mem_port_addr_out));
    endproperty

    // one writeback slot, a load or a store
    property p_ready_vs_store;
        @(posedge clk) disable iff (!rst)
        !(mem_port_ready_out && mem_port_valid_out);
    endproperty

    property p_ctrl_known;
        @(posedge clk) disable iff (!rst)
        !$isunknown({proc_rdy, mem_port_ready_out, mem_port_valid_out});
    endproperty

    a_load_hold: assert property (p_load_hold)
        else $error("load request dropped or address moved before data");
    a_ready_vs_store: assert property (p_ready_vs_store)
        else $error("load request and store pulse in the same cycle");
    a_ctrl_known: assert property (p_ctrl_known)
        else $error("control output unknown after reset");

endmodule

bind rvv_proc_main rvv_sva u_rvv_sva (
    .clk                (clk),
    .rst                (rst),
    .proc_rdy           (proc_rdy),
    .mem_port_ready_out (mem_port_ready_out),
    .mem_port_valid_in  (mem_port_valid_in),
    .mem_port_addr_out  (mem_port_addr_out),
    .mem_port_valid_out (mem_port_valid_out)
);

// ==== tb/rvv_tb.sv ====
`timescale 1ns/10ps
`include "rvv_macros.svh"

module rvv_tb;

    localparam int N_INSN = 300;
    localparam int MAX_CYCLES = N_INSN * 12;
    localparam logic [31:0] SEED = 32'h01613c80;

    logic                   clk;
    logic                   rst;
    logic [`RVV_INSN_W-1:0] insn_in;
    logic [`RVV_VLEN-1:0]   mem_port_in;
    logic                   mem_port_valid_in;
    logic                   mem_port_ready_out;
    logic [`RVV_VLEN-1:0]   mem_port_out;
    logic [`RVV_MEM_AW-1:0] mem_port_addr_out;
    logic                   mem_port_valid_out;
    logic                   proc_rdy;

    // program plus everything the model expects from it
    logic [`RVV_INSN_W-1:0] prog [N_INSN];
    logic [`RVV_VLEN-1:0]   model_regs [`RVV_NUM_VEC];
    logic [`RVV_VLEN-1:0]   load_data [$];
    int unsigned            load_wait [$];
    logic [`RVV_MEM_AW-1:0] exp_ld_addr [$];
    logic [`RVV_VLEN-1:0]   exp_st_data [$];
    logic [`RVV_MEM_AW-1:0] exp_st_addr [$];
    int                     st_cnt;
    int                     ld_cnt;

    rvv_proc_main u_rvv_proc_main (
        .clk                (clk),
        .rst                (rst),
        .insn_in            (insn_in),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .proc_rdy           (proc_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_store(input string name,
                               input logic [`RVV_VLEN-1:0] exp_data,
                               input logic [`RVV_MEM_AW-1:0] exp_addr,
                               input logic [`RVV_VLEN-1:0] act_data,
                               input logic [`RVV_MEM_AW-1:0] act_addr);
        if (exp_data !== act_data || exp_addr !== act_addr) begin
            $display("FAIL %s expected data %h addr %h actual data %h addr %h",
                     name, exp_data, exp_addr, act_data, act_addr);
            $display("Test FAILED");
            $fatal(1, "store pulse does not match the model");
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [`RVV_MEM_AW-1:0] exp_addr,
                              input logic [`RVV_MEM_AW-1:0] act_addr);
        if (exp_addr !== act_addr) begin
            $display("FAIL %s expected %h actual %h", name, exp_addr, act_addr);
            $display("Test FAILED");
            $fatal(1, "load request address does not match the model");
        end
    endtask

    task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
        if (exp_cnt != act_cnt) begin
            $display("FAIL %s expected %0d actual %0d", name, exp_cnt, act_cnt);
            $display("Test FAILED");
            $fatal(1, "transfer count does not match the model");
        end
    endtask

    // every byte on its own, add and sub wrap at 256
    function automatic logic [`RVV_VLEN-1:0] lane_math(input logic [5:0] funct6,
                                                       input logic [`RVV_VLEN-1:0] vs2v,
                                                       input logic [`RVV_VLEN-1:0] opa);
        logic [`RVV_VLEN-1:0] r;
        logic [7:0]           x;
        logic [7:0]           y;
        r = '0;
        for (int i = 0; i < `RVV_LANES; i++) begin
            x = vs2v[8*i +: 8];
            y = opa[8*i +: 8];
            case (funct6)
                6'b000000: r[8*i +: 8] = x + y;
                // vs2 minus vs1
                6'b000010: r[8*i +: 8] = x - y;
                6'b001001: r[8*i +: 8] = x & y;
                6'b001010: r[8*i +: 8] = x | y;
                default:   r[8*i +: 8] = x ^ y;
            endcase
        end
        return r;
    endfunction

    // vm bit set, unmasked
    function automatic logic [31:0] enc_vop(input logic [5:0] f6, input logic [2:0] f3,
                                            input logic [4:0] vs2, input logic [4:0] src1,
                                            input logic [4:0] vd);
        return {f6, 1'b1, vs2, src1, f3, vd, `RVV_OPC_VOP};
    endfunction

    // nf 0, mew 0, lumop 0, 8-bit width
    function automatic logic [31:0] enc_mem(input logic [6:0] opc, input logic [1:0] mop,
                                            input logic [4:0] addr, input logic [4:0] reg_idx);
        return {3'b000, 1'b0, mop, 1'b1, 5'b00000, addr, 3'b000, reg_idx, opc};
    endfunction

    // sel 4 only for the vv forms
    function automatic logic [5:0] pick_funct6(input int unsigned sel);
        case (sel)
            0: return 6'b000000;
            1: return 6'b001001;
            2: return 6'b001010;
            3: return 6'b001011;
            default: return 6'b000010;
        endcase
    endfunction

    // forms outside the kept set
    function automatic logic [31:0] noop_word(input int unsigned kind, input logic [4:0] a,
                                              input logic [4:0] b, input logic [4:0] c,
                                              input logic [4:0] addr);
        case (kind)
            // vsub.vi is not in the ISA
            0: return enc_vop(6'b000010, 3'b011, a, b, c);
            // config space
            1: return enc_vop(6'b000000, 3'b111, a, b, c);
            // vmv.v.v, unsupported funct6
            2: return enc_vop(6'b010111, 3'b000, a, b, c);
            // strided load
            default: return enc_mem(`RVV_OPC_LOAD, 2'b10, addr, c);
        endcase
    endfunction

    // random program run through the model in order
    task automatic build_program();
        int unsigned          pick;
        logic [5:0]           f6;
        logic [4:0]           vd;
        logic [4:0]           vs1;
        logic [4:0]           vs2;
        logic [4:0]           addr;
        logic [4:0]           simm5;
        logic [7:0]           imm8;
        logic [`RVV_VLEN-1:0] ld_word;
        for (int n = 0; n < N_INSN; n++) begin
            pick = $urandom_range(99, 0);
            // few registers so hazards come often
            vd   = 5'($urandom_range(7, 0));
            vs1  = 5'($urandom_range(7, 0));
            vs2  = 5'($urandom_range(7, 0));
            addr = 5'($urandom_range(31, 0));
            if (pick < 20) begin
                prog[n] = enc_mem(`RVV_OPC_LOAD, 2'b00, addr, vd);
                ld_word = {$urandom, $urandom};
                load_data.push_back(ld_word);
                load_wait.push_back($urandom_range(3, 0));
                exp_ld_addr.push_back(addr);
                model_regs[vd] = ld_word;
            end else if (pick < 40) begin
                // vs3 in the vd field
                prog[n] = enc_mem(`RVV_OPC_STORE, 2'b00, addr, vs2);
                exp_st_data.push_back(model_regs[vs2]);
                exp_st_addr.push_back(addr);
            end else if (pick < 65) begin
                f6 = pick_funct6($urandom_range(4, 0));
                prog[n] = enc_vop(f6, 3'b000, vs2, vs1, vd);
                model_regs[vd] = lane_math(f6, model_regs[vs2], model_regs[vs1]);
            end else if (pick < 85) begin
                // simm5 sits in the vs1 field
                // drawn over all 32 values so negatives appear
                f6 = pick_funct6($urandom_range(3, 0));
                simm5 = 5'($urandom_range(31, 0));
                prog[n] = enc_vop(f6, 3'b011, vs2, simm5, vd);
                imm8 = 8'($signed(simm5));
                model_regs[vd] = lane_math(f6, model_regs[vs2], {`RVV_LANES{imm8}});
            end else begin
                prog[n] = noop_word(pick % 4, vs2, vs1, vd, addr);
            end
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Test FAILED");
        $fatal(1, "timeout, program did not finish within %0d cycles", MAX_CYCLES);
    end

    // load data one or more cycles after the request
    initial begin : mem_responder
        logic                   need;
        logic                   armed;
        int unsigned            wait_left;
        logic [`RVV_MEM_AW-1:0] req_addr;
        need      = 1'b0;
        armed     = 1'b0;
        wait_left = 0;
        req_addr  = '0;
        @(posedge rst);
        forever begin
            @(negedge clk);
            // a beat already given this cycle is not a new request
            need     = mem_port_ready_out && !mem_port_valid_in;
            req_addr = mem_port_addr_out;
            @(posedge clk);
            #1;
            mem_port_valid_in = 1'b0;
            if (need) begin
                if (!armed) begin
                    if (ld_cnt >= load_data.size()) begin
                        $display("Test FAILED");
                        $fatal(1, "load request with no load left in the program");
                    end
                    check_addr($sformatf("load %0d address", ld_cnt), exp_ld_addr[ld_cnt],
                               req_addr);
                    wait_left = load_wait[ld_cnt];
                    armed     = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_port_valid_in = 1'b1;
                    mem_port_in       = load_data[ld_cnt];
                    ld_cnt++;
                    armed = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : store_monitor
        @(posedge rst);
        forever begin
            @(negedge clk);
            if (mem_port_valid_out) begin
                // pulses past the program are only counted
                if (st_cnt < exp_st_data.size()) begin
                    check_store($sformatf("store %0d", st_cnt), exp_st_data[st_cnt],
                                exp_st_addr[st_cnt], mem_port_out, mem_port_addr_out);
                end
                st_cnt++;
            end
        end
    end

    initial begin : main
        int unsigned seed_ret;
        int          idx;
        logic        rdy_seen;
        seed_ret          = $urandom(SEED);
        rst               = 1'b0;
        insn_in           = '0;
        mem_port_in       = '0;
        mem_port_valid_in = 1'b0;
        st_cnt            = 0;
        ld_cnt            = 0;
        for (int r = 0; r < `RVV_NUM_VEC; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (3) @(posedge clk);
        #1;
        rst     = 1'b1;
        idx     = 0;
        insn_in = prog[0];
        // next word only after an edge that took the current one
        while (idx < N_INSN) begin
            @(negedge clk);
            rdy_seen = proc_rdy;
            @(posedge clk);
            #1;
            if (rdy_seen) begin
                idx++;
                insn_in = (idx < N_INSN) ? prog[idx] : '0;
            end
        end
        // drain the pipe, idle time catches stray pulses
        while (st_cnt < exp_st_data.size()) @(posedge clk);
        repeat (20) @(posedge clk);
        check_count("store count", exp_st_data.size(), st_cnt);
        check_count("load count", load_data.size(), ld_cnt);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/rvv_pkg.sv
src/vec_lane.sv
src/vec_regfile.sv
src/rvv_decoder.sv
src/vec_writeback.sv
src/rvv_proc_main.sv
tb/rvv_sva.sv
tb/rvv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vector datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    -f verilog.f \
    --top-module rvv_tb \
    -Mdir obj_dir -o rvv_sim

./obj_dir/rvv_sim
